//--- verilog/ofdm_mod_pkg.sv
package ofdm_mod_pkg;

    //////////////////////////////////////////////////
    // Modulation schemes
    //////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        BPSK  = 3'd0,
        QPSK  = 3'd1,
        QAM16 = 3'd2
    } modulation_e;

    // Boundary between inner and outer QAM16 levels on each axis
    localparam logic signed [15:0] QAM16_THRESHOLD = 16'sd8192;

    // Eight subcarriers at four bits each
    localparam int MAX_BITS_PER_GROUP = 32;

    // Largest symbol payload, reached with QAM16
    localparam int BUFFER_BYTES = 96;

    //////////////////////////////////////////////////
    // Demapper output word
    //////////////////////////////////////////////////

    typedef struct packed {
        modulation_e                   modulation;
        logic [MAX_BITS_PER_GROUP-1:0] data;
    } demap_word_t;

    // Also the number of bytes that one group of eight produces
    function automatic logic [2:0] bits_per_subcarrier(input modulation_e mod);
        case (mod)
            QPSK:    return 3'd2;
            QAM16:   return 3'd4;
            default: return 3'd1;
        endcase
    endfunction

endpackage

//--- verilog/ofdm_frame_pkg.sv
package ofdm_frame_pkg;
    import ofdm_mod_pkg::*;

    //////////////////////////////////////////////////
    // Frame geometry
    //////////////////////////////////////////////////

    localparam int FFT_POINTS        = 256;
    localparam int DATA_SUBCARRIERS  = 192;
    localparam int GROUP_SIZE        = 8;
    localparam int GROUPS_PER_SYMBOL = DATA_SUBCARRIERS / GROUP_SIZE;
    localparam int SAMPLE_WIDTH      = 16;

    // Used subcarriers 1..100 and 156..255, DC and guard bands are empty
    localparam logic [FFT_POINTS-1:0] USED_SUBCARRIER_MASK =
        ({FFT_POINTS{1'b1}} << 156) | (((256'd1 << 101) - 256'd1) & ~256'd1);

    // Pilots at +/-13, +/-38, +/-63, +/-88
    localparam logic [FFT_POINTS-1:0] PILOT_MASK =
        (256'd1 << 13)  | (256'd1 << 38)  | (256'd1 << 63)  | (256'd1 << 88) |
        (256'd1 << 168) | (256'd1 << 193) | (256'd1 << 218) | (256'd1 << 243);

    localparam logic [FFT_POINTS-1:0] DATA_SUBCARRIER_MASK =
        USED_SUBCARRIER_MASK & ~PILOT_MASK;

    //////////////////////////////////////////////////
    // Sample and group types
    //////////////////////////////////////////////////

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] i;
        logic signed [SAMPLE_WIDTH-1:0] q;
    } iq_sample_t;

    typedef struct packed {
        modulation_e                     modulation;
        iq_sample_t [GROUP_SIZE-1:0]     samples;
    } iq_group_t;

    // 24, 48 or 96 bytes per symbol
    function automatic logic [6:0] bytes_per_symbol(input modulation_e mod);
        return 7'(DATA_SUBCARRIERS * int'(bits_per_subcarrier(mod)) / 8);
    endfunction

endpackage

//--- verilog/subcarrier_selector.sv
`timescale 1ns/1ps

module subcarrier_selector
    import ofdm_mod_pkg::*, ofdm_frame_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        sample_valid_i,
    input  iq_sample_t  sample_i,
    input  modulation_e modulation_i,
    input  logic        sending_i,
    output iq_group_t   group_o,
    output logic        group_valid_o
);

    logic [$clog2(FFT_POINTS)-1:0]  sc_cnt_q;
    logic [$clog2(GROUP_SIZE)-1:0]  slot_q;
    modulation_e                    mod_q;
    iq_sample_t [GROUP_SIZE-1:0]    slots_q;
    logic                           accept;
    logic                           is_data;

    // Nothing is taken in while the symbol buffer drains
    assign accept  = sample_valid_i && !sending_i;
    assign is_data = DATA_SUBCARRIER_MASK[sc_cnt_q];

    //////////////////////////////////////////////////
    // Subcarrier and slot counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sc_cnt_q      <= '0;
            slot_q        <= '0;
            mod_q         <= BPSK;
            group_valid_o <= 1'b0;
        end
        else
        begin
            group_valid_o <= 1'b0;
            if (accept)
            begin
                // Counter wraps from 255 back to 0 on its own
                sc_cnt_q <= sc_cnt_q + 1'b1;
                if (sc_cnt_q == '0)
                    mod_q <= modulation_i;
                if (is_data)
                begin
                    slot_q <= slot_q + 1'b1;
                    if (slot_q == GROUP_SIZE - 1)
                        group_valid_o <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Group slots
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept && is_data)
            slots_q[slot_q] <= sample_i;
    end

    assign group_o.modulation = mod_q;
    assign group_o.samples    = slots_q;

endmodule

//--- verilog/constellation_demapper.sv
`timescale 1ns/1ps

module constellation_demapper
    import ofdm_mod_pkg::*, ofdm_frame_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  iq_group_t   group_i,
    input  logic        group_valid_i,
    output demap_word_t word_o,
    output logic        word_valid_o
);

    logic [GROUP_SIZE-1:0]          sign_i;
    logic [GROUP_SIZE-1:0]          sign_q;
    logic [GROUP_SIZE-1:0]          inner_i;
    logic [GROUP_SIZE-1:0]          inner_q;
    logic [MAX_BITS_PER_GROUP-1:0]  bits_c;

    //////////////////////////////////////////////////
    // Per-subcarrier decisions
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int s = 0; s < GROUP_SIZE; s++)
        begin
            sign_i[s] = group_i.samples[s].i[SAMPLE_WIDTH-1];
            sign_q[s] = group_i.samples[s].q[SAMPLE_WIDTH-1];
            // Two-sided compare, so -32768 needs no special case
            inner_i[s] = (group_i.samples[s].i < QAM16_THRESHOLD) &&
                         (group_i.samples[s].i > -QAM16_THRESHOLD);
            inner_q[s] = (group_i.samples[s].q < QAM16_THRESHOLD) &&
                         (group_i.samples[s].q > -QAM16_THRESHOLD);
        end
    end

    // Subcarrier s lands at bit s times bits per subcarrier
    always_comb
    begin
        bits_c = '0;
        case (group_i.modulation)
            QPSK:
            begin
                for (int s = 0; s < GROUP_SIZE; s++)
                begin
                    bits_c[2*s]     = sign_i[s];
                    bits_c[2*s + 1] = sign_q[s];
                end
            end
            QAM16:
            begin
                for (int s = 0; s < GROUP_SIZE; s++)
                begin
                    bits_c[4*s]     = sign_i[s];
                    bits_c[4*s + 1] = inner_i[s];
                    bits_c[4*s + 2] = sign_q[s];
                    bits_c[4*s + 3] = inner_q[s];
                end
            end
            default:
            begin
                bits_c[GROUP_SIZE-1:0] = sign_i;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            word_valid_o <= 1'b0;
        else
            word_valid_o <= group_valid_i;
    end

    always_ff @(posedge clk)
    begin
        if (group_valid_i)
        begin
            word_o.data       <= bits_c;
            word_o.modulation <= group_i.modulation;
        end
    end

endmodule

//--- verilog/payload_assembler.sv
`timescale 1ns/1ps

module payload_assembler
    import ofdm_mod_pkg::*, ofdm_frame_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  demap_word_t word_i,
    input  logic        word_valid_i,
    input  logic        byte_ready_i,
    output logic [7:0]  byte_o,
    output logic        byte_valid_o,
    output logic        sending_o
);

    typedef enum logic
    {
        COLLECT,
        SEND
    } state_e;

    typedef logic [$clog2(BUFFER_BYTES)-1:0] ptr_t;

    state_e                                 state_q;
    demap_word_t                            word_q;
    logic                                   word_en_q;
    ptr_t                                   wr_ptr_q;
    ptr_t                                   rd_ptr_q;
    logic [$clog2(GROUPS_PER_SYMBOL)-1:0]   grp_cnt_q;
    modulation_e                            sym_mod_q;
    logic [7:0]                             buf_q [BUFFER_BYTES];

    assign sending_o = (state_q == SEND);

    //////////////////////////////////////////////////
    // Word staging
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            word_en_q <= 1'b0;
        else
            word_en_q <= word_valid_i && (state_q == COLLECT);
    end

    always_ff @(posedge clk)
    begin
        if (word_valid_i)
            word_q <= word_i;
    end

    //////////////////////////////////////////////////
    // Symbol byte buffer
    //////////////////////////////////////////////////

    // A group yields as many bytes as bits per subcarrier, low byte first
    always_ff @(posedge clk)
    begin
        if (word_en_q && state_q == COLLECT)
        begin
            for (int b = 0; b < MAX_BITS_PER_GROUP / 8; b++)
            begin
                if (b < int'(bits_per_subcarrier(word_q.modulation)))
                    buf_q[wr_ptr_q + ptr_t'(b)] <= word_q.data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == SEND && byte_ready_i)
            byte_o <= buf_q[rd_ptr_q];
    end

    //////////////////////////////////////////////////
    // Collect / send FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q      <= COLLECT;
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            grp_cnt_q    <= '0;
            sym_mod_q    <= BPSK;
            byte_valid_o <= 1'b0;
        end
        else
        begin
            byte_valid_o <= 1'b0;
            case (state_q)
                COLLECT:
                begin
                    if (word_en_q)
                    begin
                        if (grp_cnt_q == GROUPS_PER_SYMBOL - 1)
                        begin
                            // Last group of the symbol written this cycle
                            grp_cnt_q <= '0;
                            wr_ptr_q  <= '0;
                            sym_mod_q <= word_q.modulation;
                            state_q   <= SEND;
                        end
                        else
                        begin
                            grp_cnt_q <= grp_cnt_q + 1'b1;
                            wr_ptr_q  <= wr_ptr_q + ptr_t'(bits_per_subcarrier(word_q.modulation));
                        end
                    end
                end
                SEND:
                begin
                    if (byte_ready_i)
                    begin
                        byte_valid_o <= 1'b1;
                        if (rd_ptr_q == ptr_t'(bytes_per_symbol(sym_mod_q) - 7'd1))
                        begin
                            rd_ptr_q <= '0;
                            state_q  <= COLLECT;
                        end
                        else
                        begin
                            rd_ptr_q <= rd_ptr_q + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state_q <= COLLECT;
                end
            endcase
        end
    end

endmodule

//--- verilog/ofdm_payload_rx.sv
`timescale 1ns/1ps

module ofdm_payload_rx
    import ofdm_mod_pkg::*, ofdm_frame_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        sample_valid_i,
    input  iq_sample_t  sample_i,
    input  modulation_e modulation_i,
    input  logic        byte_ready_i,
    output logic        byte_valid_o,
    output logic [7:0]  byte_o,
    output logic        busy_o
);

    iq_group_t      group;
    logic           group_valid;
    demap_word_t    word;
    logic           word_valid;
    logic           sending;

    // Data subcarriers in, groups of eight out
    subcarrier_selector u_selector (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .modulation_i   (modulation_i),
        .sending_i      (sending),
        .group_o        (group),
        .group_valid_o  (group_valid)
    );

    constellation_demapper u_demapper (
        .clk            (clk),
        .reset          (reset),
        .group_i        (group),
        .group_valid_i  (group_valid),
        .word_o         (word),
        .word_valid_o   (word_valid)
    );

    payload_assembler u_assembler (
        .clk            (clk),
        .reset          (reset),
        .word_i         (word),
        .word_valid_i   (word_valid),
        .byte_ready_i   (byte_ready_i),
        .byte_o         (byte_o),
        .byte_valid_o   (byte_valid_o),
        .sending_o      (sending)
    );

    // Busy for as long as the buffer drains
    assign busy_o = sending;

endmodule

//--- verif/tb_ofdm_payload_rx.sv
`timescale 1ns/1ps

module tb_ofdm_payload_rx
    import ofdm_mod_pkg::*, ofdm_frame_pkg::*;
();

    localparam int NUM_SYMBOLS = 12;
    localparam int WAIT_LIMIT  = 64;
    localparam int DRAIN_LIMIT = 2000;

    logic        clk;
    logic        reset;
    logic        sample_valid_i;
    iq_sample_t  sample_i;
    modulation_e modulation_i;
    logic        byte_ready_i;
    logic        byte_valid_o;
    logic [7:0]  byte_o;
    logic        busy_o;

    logic [7:0]  expected_q [$];
    int          byte_errors;
    int          count_errors;
    int          protocol_errors;
    bit          timed_out;

    ofdm_payload_rx u_ofdm_payload_rx (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .modulation_i   (modulation_i),
        .byte_ready_i   (byte_ready_i),
        .byte_valid_o   (byte_valid_o),
        .byte_o         (byte_o),
        .busy_o         (busy_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Data carriers are 1..100 and 156..255 without the eight pilots
    function automatic bit is_data_carrier(input int k);
        bit used;
        bit pilot;
        used  = (k >= 1 && k <= 100) || (k >= 156 && k <= 255);
        pilot = (k == 13) || (k == 38) || (k == 63) || (k == 88) ||
                (k == 168) || (k == 193) || (k == 218) || (k == 243);
        return used && !pilot;
    endfunction

    function automatic int carrier_bits(input modulation_e mod);
        case (mod)
            QPSK:    return 2;
            QAM16:   return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic [3:0] demap_bits(input iq_sample_t s, input modulation_e mod);
        int         mag_i;
        int         mag_q;
        logic [3:0] b;
        mag_i = (s.i < 0) ? -int'(s.i) : int'(s.i);
        mag_q = (s.q < 0) ? -int'(s.q) : int'(s.q);
        b = '0;
        case (mod)
            QPSK:    b = {2'b00, s.q < 0, s.i < 0};
            QAM16:   b = {mag_q < int'(QAM16_THRESHOLD), s.q < 0,
                          mag_i < int'(QAM16_THRESHOLD), s.i < 0};
            default: b[0] = s.i < 0;
        endcase
        return b;
    endfunction

    // QAM16 symbols get many values right at the inner/outer boundary
    function automatic logic signed [15:0] data_value(input modulation_e mod);
        logic signed [15:0] value;
        if (mod == QAM16 && $urandom_range(7, 0) < 3)
        begin
            value = 16'sd8191 + 16'($urandom_range(2, 0));
            if ($urandom_range(1, 0) == 1)
                value = -value;
            return value;
        end
        return 16'($urandom);
    endfunction

    // Pilots and guards carry extremes
    function automatic logic signed [15:0] filler_value();
        case ($urandom_range(2, 0))
            0:       return 16'sh7fff;
            1:       return 16'sh8000;
            default: return 16'($urandom);
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_byte(input logic [7:0] actual);
        logic [7:0] expected;
        if (expected_q.size() == 0)
        begin
            byte_errors++;
            $display("[ERROR] %0t: extra byte %h beyond the end of the symbol", $time, actual);
        end
        else
        begin
            expected = expected_q.pop_front();
            if (actual !== expected)
            begin
                byte_errors++;
                $display("[ERROR] %0t: byte %h, expected %h", $time, actual, expected);
            end
        end
    endtask

    task automatic check_count(input int actual, input modulation_e mod);
        int expected;
        expected = 192 * carrier_bits(mod) / 8;
        if (actual != expected)
        begin
            count_errors++;
            $display("[ERROR] %0t: %0d bytes for %s, expected %0d",
                     $time, actual, mod.name(), expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            protocol_errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic offer_junk();
        sample_valid_i = 1'($urandom_range(1, 0));
        sample_i       = iq_sample_t'($urandom);
        modulation_i   = modulation_e'($urandom_range(2, 0));
    endtask

    task automatic send_symbol(input modulation_e mod);
        iq_sample_t  s;
        logic [31:0] word;
        int          slot;
        int          nb;
        nb   = carrier_bits(mod);
        word = '0;
        slot = 0;
        for (int k = 0; k < 256; k++)
        begin
            if (is_data_carrier(k))
            begin
                s.i  = data_value(mod);
                s.q  = data_value(mod);
                word = word | (32'(demap_bits(s, mod)) << (slot * nb));
                slot++;
                if (slot == 8)
                begin
                    for (int b = 0; b < nb; b++)
                        expected_q.push_back(word[8*b +: 8]);
                    word = '0;
                    slot = 0;
                end
            end
            else
            begin
                s.i = filler_value();
                s.q = filler_value();
            end
            // Occasional idle cycle between samples
            if ($urandom_range(3, 0) == 0)
            begin
                sample_valid_i = 1'b0;
                sample_i       = iq_sample_t'($urandom);
                @(negedge clk);
            end
            sample_valid_i = 1'b1;
            sample_i       = s;
            modulation_i   = (k == 0) ? mod : modulation_e'($urandom_range(2, 0));
            @(negedge clk);
            check_flag("busy_o", busy_o, 1'b0);
            check_flag("byte_valid_o", byte_valid_o, 1'b0);
        end
        sample_valid_i = 1'b0;
    endtask

    task automatic wait_busy_high();
        int cycles;
        cycles = 0;
        while (!busy_o && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!busy_o)
        begin
            timed_out = 1'b1;
            $display("Timeout: busy_o never rose after the last sample of a symbol");
        end
        else if (cycles + 1 != 4)
        begin
            protocol_errors++;
            $display("[ERROR] %0t: busy_o rose %0d cycles after subcarrier 255, expected 4",
                     $time, cycles + 1);
        end
    endtask

    // Random ready, with junk samples offered the whole time
    task automatic drain_symbol(input modulation_e mod);
        int cycles;
        int received;
        bit ready_prev;
        cycles       = 0;
        received     = 0;
        byte_ready_i = 1'($urandom_range(1, 0));
        offer_junk();
        ready_prev   = byte_ready_i;
        while (cycles < DRAIN_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            check_flag("byte_valid_o", byte_valid_o, ready_prev);
            if (byte_valid_o)
            begin
                check_byte(byte_o);
                received++;
            end
            if (!busy_o)
                break;
            byte_ready_i = 1'($urandom_range(1, 0));
            offer_junk();
            ready_prev   = byte_ready_i;
        end
        sample_valid_i = 1'b0;
        byte_ready_i   = 1'b0;
        if (busy_o)
        begin
            timed_out = 1'b1;
            $display("Timeout: busy_o stayed high while draining the symbol bytes");
        end
        else
            check_count(received, mod);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        modulation_e mod;
        void'($urandom(32'h3d46ee98));
        reset           = 1'b1;
        sample_valid_i  = 1'b0;
        sample_i        = '0;
        modulation_i    = BPSK;
        byte_ready_i    = 1'b0;
        byte_errors     = 0;
        count_errors    = 0;
        protocol_errors = 0;
        timed_out       = 1'b0;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_flag("byte_valid_o", byte_valid_o, 1'b0);
        check_flag("busy_o", busy_o, 1'b0);

        // BPSK, QPSK and QAM16 first, random order after that
        for (int sym = 0; sym < NUM_SYMBOLS; sym++)
        begin
            if (sym < 3)
                mod = modulation_e'(sym);
            else
                mod = modulation_e'($urandom_range(2, 0));
            send_symbol(mod);
            wait_busy_high();
            if (timed_out)
                break;
            drain_symbol(mod);
            if (timed_out)
                break;
            expected_q.delete();
        end

        $display("Errors: %0d byte, %0d count, %0d protocol, %0d timeout",
                 byte_errors, count_errors, protocol_errors, timed_out);
        if (!timed_out && byte_errors + count_errors + protocol_errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- tb.f
verilog/ofdm_mod_pkg.sv
verilog/ofdm_frame_pkg.sv
verilog/subcarrier_selector.sv
verilog/constellation_demapper.sv
verilog/payload_assembler.sv
verilog/ofdm_payload_rx.sv
verif/tb_ofdm_payload_rx.sv

//--- Makefile
# Verilator flow for the OFDM payload stage

TOP := tb_ofdm_payload_rx
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module ofdm_payload_rx

obj_dir/V$(TOP): tb.f verilog/*.sv verif/*.sv
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
		echo "Testbench reported failure"; \
		exit 1; \
	fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
